/* hdl/cache_pkg.sv */
`default_nettype none

package cache_pkg;

  // Wishbone bus widths
  localparam int ADDR_W = 32;
  localparam int DATA_W = 32;
  localparam int SEL_W  = DATA_W / 8;

  // Byte offset bits below the word index
  localparam int OFFSET_W = 2;

  // Controller states
  typedef enum logic [1:0] {
    // Idle, or checking the current request
    ST_LOOKUP    = 2'd0,
    // Victim going out to memory
    ST_WRITEBACK = 2'd1,
    // Missed word coming in from memory
    ST_FILL      = 2'd2,
    // Processor ack
    ST_RESPOND   = 2'd3
  } cache_state_e;

endpackage

`default_nettype wire

/* hdl/cache_tag_store.sv */
`timescale 1ns/10ps
`default_nettype none

module cache_tag_store
  import cache_pkg::*;
#(
  parameter int NUM_SETS = 4
) (
  input  wire                                             ACLK,
  input  wire                                             ARESETn,
  input  wire  [ADDR_W-1:0]                               cpu_adr,
  input  wire                                             write_hit,
  input  wire                                             fill,
  input  wire                                             fill_merge,
  output logic                                            hit,
  output logic                                            victim_dirty,
  output logic [ADDR_W-$clog2(NUM_SETS)-OFFSET_W-1:0]     victim_tag
);

  localparam int IDX_W = $clog2(NUM_SETS);
  localparam int TAG_W = ADDR_W - IDX_W - OFFSET_W;

  logic [TAG_W-1:0]    tag_q [NUM_SETS];
  logic [NUM_SETS-1:0] valid_q;
  logic [NUM_SETS-1:0] dirty_q;

  logic [IDX_W-1:0]    idx;
  logic [TAG_W-1:0]    req_tag;

  // Address split: tag | index | byte offset
  assign idx     = cpu_adr[OFFSET_W +: IDX_W];
  assign req_tag = cpu_adr[ADDR_W-1 -: TAG_W];

  // Lookup is combinational on the held request address
  assign hit          = valid_q[idx] && (tag_q[idx] == req_tag);
  assign victim_dirty = valid_q[idx] && dirty_q[idx];
  assign victim_tag   = tag_q[idx];

  // Valid and dirty flags
  always_ff @(posedge ACLK) begin
    if (!ARESETn) begin
      valid_q <= '0;
      dirty_q <= '0;
    end else if (fill) begin
      valid_q[idx] <= 1'b1;
      // A write miss leaves the filled line modified
      dirty_q[idx] <= fill_merge;
    end else if (write_hit) begin
      dirty_q[idx] <= 1'b1;
    end
  end

  // Tag array only changes when a new line is brought in
  always_ff @(posedge ACLK) begin
    if (fill) begin
      tag_q[idx] <= req_tag;
    end
  end

endmodule

`default_nettype wire

/* hdl/cache_data_store.sv */
`timescale 1ns/10ps
`default_nettype none

module cache_data_store
  import cache_pkg::*;
#(
  parameter int NUM_SETS = 4
) (
  input  wire               ACLK,
  input  wire  [ADDR_W-1:0] cpu_adr,
  input  wire  [DATA_W-1:0] cpu_dat_w,
  input  wire  [SEL_W-1:0]  cpu_sel,
  input  wire  [DATA_W-1:0] mem_dat_r,
  input  wire               write_hit,
  input  wire               fill,
  input  wire               fill_merge,
  output logic [DATA_W-1:0] line_data
);

  localparam int IDX_W = $clog2(NUM_SETS);

  logic [DATA_W-1:0] line_q [NUM_SETS];

  logic [IDX_W-1:0]  idx;
  logic              use_sel;
  logic [DATA_W-1:0] merged;

  assign idx       = cpu_adr[OFFSET_W +: IDX_W];
  assign line_data = line_q[idx];

  // Processor bytes apply on a write hit, and on a fill for a write miss
  assign use_sel = write_hit || (fill && fill_merge);

  // Base word is the fetched word on a fill, the stored word otherwise
  always_comb begin
    merged = fill ? mem_dat_r : line_q[idx];
    for (int b = 0; b < SEL_W; b++) begin
      if (use_sel && cpu_sel[b]) begin
        merged[8*b +: 8] = cpu_dat_w[8*b +: 8];
      end
    end
  end

  always_ff @(posedge ACLK) begin
    if (write_hit || fill) begin
      line_q[idx] <= merged;
    end
  end

endmodule

`default_nettype wire

/* hdl/cache_ctrl.sv */
`timescale 1ns/10ps
`default_nettype none

module cache_ctrl
  import cache_pkg::*;
#(
  parameter int NUM_SETS = 4
) (
  input  wire                                          ACLK,
  input  wire                                          ARESETn,
  // Processor request
  input  wire                                          cpu_cyc,
  input  wire                                          cpu_stb,
  input  wire                                          cpu_we,
  input  wire  [ADDR_W-1:0]                            cpu_adr,
  // Lookup results
  input  wire                                          hit,
  input  wire                                          victim_dirty,
  input  wire  [ADDR_W-$clog2(NUM_SETS)-OFFSET_W-1:0]  victim_tag,
  input  wire  [DATA_W-1:0]                            line_data,
  // Memory response
  input  wire  [DATA_W-1:0]                            mem_dat_r,
  input  wire                                          mem_ack,
  // Store updates
  output logic                                         write_hit,
  output logic                                         fill,
  output logic                                         fill_merge,
  // Processor response
  output logic [DATA_W-1:0]                            cpu_dat_r,
  output logic                                         cpu_ack,
  // Memory request
  output logic                                         mem_cyc,
  output logic                                         mem_stb,
  output logic                                         mem_we,
  output logic [ADDR_W-1:0]                            mem_adr,
  output logic [DATA_W-1:0]                            mem_dat_w,
  output logic [SEL_W-1:0]                             mem_sel
);

  localparam int IDX_W = $clog2(NUM_SETS);

  cache_state_e state;

  logic              req;
  logic              lookup_req;
  logic              wb_done;
  logic [IDX_W-1:0]  idx;
  logic [ADDR_W-1:0] req_adr;
  logic [ADDR_W-1:0] victim_adr;

  // The request stays up during the ack cycle, so it is ignored there
  assign req        = cpu_cyc && cpu_stb && !cpu_ack;
  assign lookup_req = (state == ST_LOOKUP) && req;

  assign idx        = cpu_adr[OFFSET_W +: IDX_W];
  assign req_adr    = {cpu_adr[ADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}};
  assign victim_adr = {victim_tag, idx, {OFFSET_W{1'b0}}};

  assign wb_done = (state == ST_WRITEBACK) && mem_stb && mem_ack;

  // Store update strobes, one cycle each
  assign write_hit  = lookup_req && hit && cpu_we;
  assign fill       = (state == ST_FILL) && mem_stb && mem_ack;
  assign fill_merge = cpu_we;

  // Blocks are one word, so memory always moves whole words
  assign mem_sel = {SEL_W{1'b1}};

  // FSM and bus control
  always_ff @(posedge ACLK) begin
    if (!ARESETn) begin
      state   <= ST_LOOKUP;
      cpu_ack <= 1'b0;
      mem_cyc <= 1'b0;
      mem_stb <= 1'b0;
      mem_we  <= 1'b0;
    end else begin
      cpu_ack <= 1'b0;
      case (state)
        ST_LOOKUP: begin
          if (req) begin
            if (hit) begin
              state <= ST_RESPOND;
            end else begin
              // Miss: start the victim write or go straight to the read
              mem_cyc <= 1'b1;
              mem_stb <= 1'b1;
              mem_we  <= victim_dirty;
              state   <= victim_dirty ? ST_WRITEBACK : ST_FILL;
            end
          end
        end

        ST_WRITEBACK: begin
          if (wb_done) begin
            // Close the write cycle, the read starts one cycle later
            mem_cyc <= 1'b0;
            mem_stb <= 1'b0;
            mem_we  <= 1'b0;
            state   <= ST_FILL;
          end
        end

        ST_FILL: begin
          if (!mem_stb) begin
            mem_cyc <= 1'b1;
            mem_stb <= 1'b1;
          end else if (mem_ack) begin
            mem_cyc <= 1'b0;
            mem_stb <= 1'b0;
            state   <= ST_RESPOND;
          end
        end

        ST_RESPOND: begin
          cpu_ack <= 1'b1;
          state   <= ST_LOOKUP;
        end

        default: begin
          state <= ST_LOOKUP;
        end
      endcase
    end
  end

  // Bus payload
  always_ff @(posedge ACLK) begin
    if (lookup_req) begin
      // Victim address only matters when a writeback follows
      mem_adr   <= victim_dirty ? victim_adr : req_adr;
      mem_dat_w <= line_data;
      if (!cpu_we) begin
        cpu_dat_r <= line_data;
      end
    end
    if (wb_done) begin
      mem_adr <= req_adr;
    end
    // Read miss returns the fetched word
    if (fill && !cpu_we) begin
      cpu_dat_r <= mem_dat_r;
    end
  end

endmodule

`default_nettype wire

/* hdl/wb_cache_top.sv */
`timescale 1ns/10ps
`default_nettype none

module wb_cache_top
  import cache_pkg::*;
#(
  parameter int NUM_SETS = 4
) (
  input  wire               ACLK,
  input  wire               ARESETn,
  // Processor side, Wishbone slave
  input  wire               cpu_cyc,
  input  wire               cpu_stb,
  input  wire               cpu_we,
  input  wire  [ADDR_W-1:0] cpu_adr,
  input  wire  [DATA_W-1:0] cpu_dat_w,
  input  wire  [SEL_W-1:0]  cpu_sel,
  output logic [DATA_W-1:0] cpu_dat_r,
  output logic              cpu_ack,
  // Memory side, Wishbone master
  output logic              mem_cyc,
  output logic              mem_stb,
  output logic              mem_we,
  output logic [ADDR_W-1:0] mem_adr,
  output logic [DATA_W-1:0] mem_dat_w,
  output logic [SEL_W-1:0]  mem_sel,
  input  wire  [DATA_W-1:0] mem_dat_r,
  input  wire               mem_ack
);

  localparam int TAG_W = ADDR_W - $clog2(NUM_SETS) - OFFSET_W;

  // Lookup results
  logic              hit;
  logic              victim_dirty;
  logic [TAG_W-1:0]  victim_tag;
  logic [DATA_W-1:0] line_data;

  // Store updates
  logic              write_hit;
  logic              fill;
  logic              fill_merge;

  // Tag and data stores see the same index every cycle
  cache_tag_store #(
    .NUM_SETS(NUM_SETS)
  ) tag_i (
    .ACLK        (ACLK),
    .ARESETn     (ARESETn),
    .cpu_adr     (cpu_adr),
    .write_hit   (write_hit),
    .fill        (fill),
    .fill_merge  (fill_merge),
    .hit         (hit),
    .victim_dirty(victim_dirty),
    .victim_tag  (victim_tag)
  );

  cache_data_store #(
    .NUM_SETS(NUM_SETS)
  ) data_i (
    .ACLK      (ACLK),
    .cpu_adr   (cpu_adr),
    .cpu_dat_w (cpu_dat_w),
    .cpu_sel   (cpu_sel),
    .mem_dat_r (mem_dat_r),
    .write_hit (write_hit),
    .fill      (fill),
    .fill_merge(fill_merge),
    .line_data (line_data)
  );

  cache_ctrl #(
    .NUM_SETS(NUM_SETS)
  ) ctrl_i (
    .ACLK        (ACLK),
    .ARESETn     (ARESETn),
    .cpu_cyc     (cpu_cyc),
    .cpu_stb     (cpu_stb),
    .cpu_we      (cpu_we),
    .cpu_adr     (cpu_adr),
    .hit         (hit),
    .victim_dirty(victim_dirty),
    .victim_tag  (victim_tag),
    .line_data   (line_data),
    .mem_dat_r   (mem_dat_r),
    .mem_ack     (mem_ack),
    .write_hit   (write_hit),
    .fill        (fill),
    .fill_merge  (fill_merge),
    .cpu_dat_r   (cpu_dat_r),
    .cpu_ack     (cpu_ack),
    .mem_cyc     (mem_cyc),
    .mem_stb     (mem_stb),
    .mem_we      (mem_we),
    .mem_adr     (mem_adr),
    .mem_dat_w   (mem_dat_w),
    .mem_sel     (mem_sel)
  );

endmodule

`default_nettype wire

/* verif/wb_mem_model.sv */
`timescale 1ns/10ps
`default_nettype none

module wb_mem_model
  import cache_pkg::*;
#(
  parameter int MEM_WAIT  = 2,
  parameter int MEM_WORDS = 256
) (
  input  wire               ACLK,
  input  wire               ARESETn,
  input  wire               cyc,
  input  wire               stb,
  input  wire               we,
  input  wire  [ADDR_W-1:0] adr,
  input  wire  [DATA_W-1:0] dat_w,
  input  wire  [SEL_W-1:0]  sel,
  output logic [DATA_W-1:0] dat_r,
  output logic              ack
);

  localparam int AW = $clog2(MEM_WORDS);

  logic [DATA_W-1:0] mem [MEM_WORDS];
  logic [AW-1:0]     widx;
  int                wait_cnt;

  assign widx = adr[AW+1:2];

  // Image word at word address a
  initial begin
    for (int a = 0; a < MEM_WORDS; a++) begin
      mem[a] = (a * 32'h01010101) ^ 32'hc0de0000;
    end
  end

  // One ack per request, MEM_WAIT cycles after the strobe is seen
  always @(posedge ACLK) begin
    if (!ARESETn) begin
      ack      <= 1'b0;
      dat_r    <= '0;
      wait_cnt <= 0;
    end else begin
      ack <= 1'b0;
      if (cyc && stb && !ack) begin
        if (wait_cnt >= MEM_WAIT) begin
          ack      <= 1'b1;
          wait_cnt <= 0;
          if (we) begin
            for (int b = 0; b < SEL_W; b++) begin
              if (sel[b]) begin
                mem[widx][8*b +: 8] <= dat_w[8*b +: 8];
              end
            end
          end else begin
            dat_r <= mem[widx];
          end
        end else begin
          wait_cnt <= wait_cnt + 1;
        end
      end
    end
  end

endmodule

`default_nettype wire

/* verif/cache_chk.sv */
`timescale 1ns/10ps
`default_nettype none

module cache_chk
  import cache_pkg::*;
(
  input wire              ACLK,
  input wire              ARESETn,
  input wire              cpu_cyc,
  input wire              cpu_stb,
  input wire              cpu_ack,
  input wire              mem_cyc,
  input wire              mem_stb,
  input wire              mem_we,
  input wire [ADDR_W-1:0] mem_adr,
  input wire [DATA_W-1:0] mem_dat_w,
  input wire [SEL_W-1:0]  mem_sel,
  input wire              mem_ack
);

  int fail_count = 0;

  // Acks only answer a live request
  cpu_ack_in_cycle: assert property (@(posedge ACLK) disable iff (!ARESETn)
    cpu_ack |-> cpu_cyc && cpu_stb)
    else begin
      $error("cpu_ack seen without cpu_cyc and cpu_stb");
      fail_count++;
    end

  mem_ack_in_cycle: assert property (@(posedge ACLK) disable iff (!ARESETn)
    mem_ack |-> mem_cyc && mem_stb)
    else begin
      $error("mem_ack seen without mem_cyc and mem_stb");
      fail_count++;
    end

  cpu_ack_single: assert property (@(posedge ACLK) disable iff (!ARESETn)
    cpu_ack |=> !cpu_ack)
    else begin
      $error("cpu_ack high for two cycles running");
      fail_count++;
    end

  mem_stb_in_cyc: assert property (@(posedge ACLK) disable iff (!ARESETn)
    mem_stb |-> mem_cyc)
    else begin
      $error("mem_stb raised outside mem_cyc");
      fail_count++;
    end

  // Blocks are one word, so writebacks carry the whole word
  mem_write_full: assert property (@(posedge ACLK) disable iff (!ARESETn)
    mem_stb && mem_we |-> mem_sel == {SEL_W{1'b1}})
    else begin
      $error("memory write with partial byte selects");
      fail_count++;
    end

  mem_req_stable: assert property (@(posedge ACLK) disable iff (!ARESETn)
    mem_stb && !mem_ack |=> mem_stb && $stable(mem_adr) && $stable(mem_we)
      && $stable(mem_dat_w) && $stable(mem_sel))
    else begin
      $error("memory request changed before mem_ack");
      fail_count++;
    end

endmodule

`default_nettype wire

/* verif/tb_top.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_top
  import cache_pkg::*;
();

  localparam int MEM_WAIT       = 2;
  localparam int MEM_WORDS      = 256;
  localparam int MEM_AW         = $clog2(MEM_WORDS);
  localparam int RESET_CYCLES   = 16;
  localparam int RAND_ACCESSES  = 200;
  // Directed tests issue 10 accesses between them
  localparam int NUM_ACCESSES   = RAND_ACCESSES + 10;
  localparam int ACCESS_CYCLES  = 2 * (MEM_WAIT + 2) + 3;
  localparam int TIMEOUT_CYCLES = 2 * (NUM_ACCESSES * ACCESS_CYCLES + RESET_CYCLES);

  logic              ACLK;
  logic              ARESETn;
  logic              cpu_cyc;
  logic              cpu_stb;
  logic              cpu_we;
  logic [ADDR_W-1:0] cpu_adr;
  logic [DATA_W-1:0] cpu_dat_w;
  logic [SEL_W-1:0]  cpu_sel;
  logic [DATA_W-1:0] cpu_dat_r;
  logic              cpu_ack;
  logic              mem_cyc;
  logic              mem_stb;
  logic              mem_we;
  logic [ADDR_W-1:0] mem_adr;
  logic [DATA_W-1:0] mem_dat_w;
  logic [SEL_W-1:0]  mem_sel;
  logic [DATA_W-1:0] mem_dat_r;
  logic              mem_ack;

  // Expected contents of every word as the processor sees it
  logic [DATA_W-1:0] shadow [MEM_WORDS];

  logic [31:0]       lcg_state;
  int                err_count;
  int                start_errors;
  int                tests_run;
  int                tests_failed;
  int                cycle_count;
  int                wr_count;
  int                rd_count;
  logic [ADDR_W-1:0] last_wr_adr;
  logic [DATA_W-1:0] last_wr_dat;
  logic [SEL_W-1:0]  last_wr_sel;

  wb_cache_top #(
    .NUM_SETS(4)
  ) dut_i (
    .ACLK     (ACLK),
    .ARESETn  (ARESETn),
    .cpu_cyc  (cpu_cyc),
    .cpu_stb  (cpu_stb),
    .cpu_we   (cpu_we),
    .cpu_adr  (cpu_adr),
    .cpu_dat_w(cpu_dat_w),
    .cpu_sel  (cpu_sel),
    .cpu_dat_r(cpu_dat_r),
    .cpu_ack  (cpu_ack),
    .mem_cyc  (mem_cyc),
    .mem_stb  (mem_stb),
    .mem_we   (mem_we),
    .mem_adr  (mem_adr),
    .mem_dat_w(mem_dat_w),
    .mem_sel  (mem_sel),
    .mem_dat_r(mem_dat_r),
    .mem_ack  (mem_ack)
  );

  wb_mem_model #(
    .MEM_WAIT (MEM_WAIT),
    .MEM_WORDS(MEM_WORDS)
  ) mem_i (
    .ACLK   (ACLK),
    .ARESETn(ARESETn),
    .cyc    (mem_cyc),
    .stb    (mem_stb),
    .we     (mem_we),
    .adr    (mem_adr),
    .dat_w  (mem_dat_w),
    .sel    (mem_sel),
    .dat_r  (mem_dat_r),
    .ack    (mem_ack)
  );

  bind wb_cache_top cache_chk chk_i (
    .ACLK     (ACLK),
    .ARESETn  (ARESETn),
    .cpu_cyc  (cpu_cyc),
    .cpu_stb  (cpu_stb),
    .cpu_ack  (cpu_ack),
    .mem_cyc  (mem_cyc),
    .mem_stb  (mem_stb),
    .mem_we   (mem_we),
    .mem_adr  (mem_adr),
    .mem_dat_w(mem_dat_w),
    .mem_sel  (mem_sel),
    .mem_ack  (mem_ack)
  );

  function automatic logic [DATA_W-1:0] image_word(input logic [31:0] word_adr);
    return (word_adr * 32'h01010101) ^ 32'hc0de0000;
  endfunction

  function automatic logic [DATA_W-1:0] merge_bytes(input logic [DATA_W-1:0] old_word,
                                                    input logic [DATA_W-1:0] new_word,
                                                    input logic [SEL_W-1:0]  sel);
    logic [DATA_W-1:0] res;
    res = old_word;
    for (int b = 0; b < SEL_W; b++) begin
      if (sel[b]) begin
        res[8*b +: 8] = new_word[8*b +: 8];
      end
    end
    return res;
  endfunction

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
  endfunction

  // Testbench checks plus bound protocol assertion failures
  function automatic int total_errors();
    return err_count + dut_i.chk_i.fail_count;
  endfunction

  initial begin
    ACLK = 1'b0;
    forever #4 ACLK = ~ACLK;
  end

  initial begin
    cycle_count = 0;
    while (cycle_count < TIMEOUT_CYCLES) begin
      @(posedge ACLK);
      cycle_count++;
    end
    $display("timeout: run stopped after %0d cycles without finishing", cycle_count);
    $display("CHECKS FAILED");
    $finish;
  end

  // Every memory write must carry the latest value of its word
  always @(negedge ACLK) begin
    if (ARESETn && mem_cyc && mem_stb && mem_ack) begin
      if (mem_we) begin
        writeback_check: assert (mem_dat_w == shadow[mem_adr[MEM_AW+1:2]])
          else begin
            $display("mismatch mem_dat_w: adr %h expected %h got %h",
                     mem_adr, shadow[mem_adr[MEM_AW+1:2]], mem_dat_w);
            err_count++;
          end
        wr_count++;
        last_wr_adr = mem_adr;
        last_wr_dat = mem_dat_w;
        last_wr_sel = mem_sel;
      end else begin
        rd_count++;
      end
    end
  end

  task automatic cpu_access(input logic              we,
                            input logic [ADDR_W-1:0] adr,
                            input logic [DATA_W-1:0] dat,
                            input logic [SEL_W-1:0]  sel);
    logic [DATA_W-1:0] expected;
    expected = shadow[adr[MEM_AW+1:2]];
    @(negedge ACLK);
    cpu_cyc   = 1'b1;
    cpu_stb   = 1'b1;
    cpu_we    = we;
    cpu_adr   = adr;
    cpu_dat_w = dat;
    cpu_sel   = sel;
    do begin
      @(negedge ACLK);
    end while (!cpu_ack);
    if (we) begin
      shadow[adr[MEM_AW+1:2]] = merge_bytes(expected, dat, sel);
    end else begin
      read_check: assert (cpu_dat_r == expected)
        else begin
          $display("mismatch cpu_dat_r: adr %h expected %h got %h", adr, expected, cpu_dat_r);
          err_count++;
        end
    end
    // Request stays up through the edge that samples the ack
    @(negedge ACLK);
    cpu_cyc = 1'b0;
    cpu_stb = 1'b0;
    cpu_we  = 1'b0;
  endtask

  task automatic end_test(input string name);
    tests_run++;
    if (total_errors() == start_errors) begin
      $display("test %0d %s: ok", tests_run, name);
    end else begin
      tests_failed++;
      $display("test %0d %s: failed with %0d errors", tests_run, name,
               total_errors() - start_errors);
    end
    start_errors = total_errors();
  endtask

  initial begin
    logic [31:0] r;
    logic [31:0] d;
    int          mem_before;
    ARESETn      = 1'b0;
    cpu_cyc      = 1'b0;
    cpu_stb      = 1'b0;
    cpu_we       = 1'b0;
    cpu_adr      = '0;
    cpu_dat_w    = '0;
    cpu_sel      = '0;
    lcg_state    = 32'h8b6f;
    err_count    = 0;
    start_errors = 0;
    tests_run    = 0;
    tests_failed = 0;
    wr_count     = 0;
    rd_count     = 0;
    for (int a = 0; a < MEM_WORDS; a++) begin
      shadow[a] = image_word(a);
    end
    repeat (RESET_CYCLES) @(posedge ACLK);
    @(negedge ACLK);
    ARESETn = 1'b1;

    cpu_access(1'b0, 32'h100, 32'h0, 4'h0);
    end_test("cold read miss");

    // Second write and read must both hit
    cpu_access(1'b0, 32'h104, 32'h0, 4'h0);
    mem_before = wr_count + rd_count;
    cpu_access(1'b1, 32'h104, 32'haabbccdd, 4'b0101);
    cpu_access(1'b0, 32'h104, 32'h0, 4'h0);
    hit_check: assert (wr_count + rd_count == mem_before)
      else begin
        $display("write hit or its read-back went out to memory");
        err_count++;
      end
    end_test("partial write hit");

    cpu_access(1'b1, 32'h208, 32'h5a000000, 4'b1000);
    cpu_access(1'b0, 32'h208, 32'h0, 4'h0);
    end_test("partial write miss merge");

    // Same set: 0x40 dirty, then evicted by 0x50, then 0x50 evicted by 0x60
    cpu_access(1'b1, 32'h040, 32'h12345678, 4'hf);
    mem_before = wr_count;
    cpu_access(1'b0, 32'h050, 32'h0, 4'h0);
    evict_check: assert (wr_count == mem_before + 1)
      else begin
        $display("dirty victim was not written back exactly once");
        err_count++;
      end
    evict_adr_check: assert (last_wr_adr == 32'h040)
      else begin
        $display("mismatch mem_adr: expected %h got %h", 32'h040, last_wr_adr);
        err_count++;
      end
    evict_sel_check: assert (last_wr_sel == 4'hf)
      else begin
        $display("mismatch mem_sel: expected %h got %h", 4'hf, last_wr_sel);
        err_count++;
      end
    evict_dat_check: assert (last_wr_dat == 32'h12345678)
      else begin
        $display("mismatch mem_dat_w: expected %h got %h", 32'h12345678, last_wr_dat);
        err_count++;
      end
    cpu_access(1'b0, 32'h060, 32'h0, 4'h0);
    cpu_access(1'b0, 32'h040, 32'h0, 4'h0);
    end_test("dirty eviction");

    for (int i = 0; i < RAND_ACCESSES; i++) begin
      r = lcg_next();
      d = lcg_next();
      cpu_access(r[16], {26'd0, r[20:17], 2'b00}, d, r[24:21]);
    end
    end_test("random mix");

    $display("%0d tests, %0d failed, %0d testbench errors, %0d assertion failures",
             tests_run, tests_failed, err_count, dut_i.chk_i.fail_count);
    if (total_errors() == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* tb.f */
hdl/cache_pkg.sv
hdl/cache_tag_store.sv
hdl/cache_data_store.sv
hdl/cache_ctrl.sv
hdl/wb_cache_top.sv
verif/wb_mem_model.sv
verif/cache_chk.sv
verif/tb_top.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_top
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
RUN_ARGS  ?= +verilator+error+limit+1000
PASS_MSG  ?= ALL CHECKS PASSED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(BUILD_DIR)/V$(TOP) $(RUN_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
